//--- Makefile
# Verilator build and run of the packet statistics testbench.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_stats_subsys \
		-Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/stats_stimulus.txt
# event <len> <err> <bcast> <mcast> | gap <idle cycles> | flush
# expect <good_pkts> <good_bytes> <err_pkts> <err_bytes> <bcast> <mcast> <runt> <giant>
event 64 0 0 0
event 1518 0 1 0
event 60 0 0 1
gap 5
event 1519 0 0 0
event 100 1 0 0
flush
event 40 1 1 0
gap 30
event 9000 0 0 1
event 63 0 0 0
gap 3
event 512 1 0 1
flush
gap 200
event 2000 1 0 0
event 256 0 1 1
gap 1
event 128 0 0 0
gap 12
flush
gap 7
expect 8 12608 4 2652 3 4 3 3

//--- bench/tb_clk_gen.sv
// Testbench clock source with a 40 ns period and an 8 cycle reset.
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

//--- bench/tb_stats_subsys.sv
// Testbench top for the packet statistics block, driven from a stimulus file.
`timescale 1ns/1ps

module tb_stats_subsys
    import stats_cfg_pkg::*;
    import stats_if_pkg::*;
;

    logic         clk;
    logic         rst;
    pkt_event_t   evt;
    logic         flush;
    stat_update_t upd;
    logic         upd_valid;
    logic         upd_ready;

    logic [31:0]  rng_state = 32'h0c9f_fdb2;
    logic [31:0]  sums [stat_cnt];
    logic [31:0]  expected [stat_cnt];
    bit           expect_seen = 0;
    bit           quiet = 0;
    bit           random_ready = 1;
    bit           prev_stall = 0;
    stat_update_t prev_upd;
    int           mismatches = 0;
    int           other_errors = 0;
    int           cycle_limit = 0;
    string        lines [$];

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    stats_subsys_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .evt       (evt),
        .flush     (flush),
        .upd       (upd),
        .upd_valid (upd_valid),
        .upd_ready (upd_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic end_run();
        $display("errors: mismatches=%0d other=%0d total=%0d",
                 mismatches, other_errors, mismatches + other_errors);
        if (mismatches + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // drives one cycle of stimulus shortly after the rising edge.
    task automatic drive_cycle(input bit v, input int len, input bit e, input bit b,
                               input bit m, input bit f);
        @(posedge clk);
        #2;
        rng_state = xorshift32(rng_state);
        evt.valid = v;
        evt.len = 16'(len);
        evt.err = e;
        evt.bcast = b;
        evt.mcast = m;
        flush = f;
        upd_ready = random_ready ? rng_state[0] : 1'b1;
    endtask

    task automatic read_stimulus();
        int    fd;
        int    r;
        string line;
        fd = $fopen("bench/stats_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (r != 0 && line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // a stimulus line that lacks fields counts as an error.
    task automatic check_fields(input int got, input int want, input string line);
        if (got != want) begin
            $display("stimulus line has %0d fields instead of %0d: %s", got, want, line);
            other_errors++;
        end
    endtask

    // outputs are sampled at the edge before the DUT registers update.
    always @(posedge clk) begin
        int idx;
        if (!rst) begin
            if (quiet && upd_valid) begin
                $display("update seen before any packet event, id %0d", upd.id);
                other_errors++;
            end
            if (prev_stall && (!upd_valid || upd != prev_upd)) begin
                $display("update changed or dropped while stalled");
                other_errors++;
            end
            if (upd_valid && upd_ready) begin
                idx = int'(upd.id) - stat_id_base;
                if (idx < 0 || idx >= stat_cnt) begin
                    $display("unknown id %0d received", upd.id);
                    other_errors++;
                end else begin
                    sums[idx] += upd.count;
                end
                if (upd.count == 0) begin
                    $display("update with a zero count for id %0d", upd.id);
                    other_errors++;
                end
            end
            prev_stall = upd_valid && !upd_ready;
            prev_upd = upd;
        end
    end

    initial begin
        wait (cycle_limit != 0);
        repeat (cycle_limit) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", cycle_limit);
        other_errors++;
        end_run();
    end

    initial begin
        string      kw;
        int         n;
        int         a;
        int         b;
        int         c;
        int         d;
        int         e [stat_cnt];
        stat_chan_e chan;
        evt = '0;
        flush = 1'b0;
        upd_ready = 1'b0;
        prev_upd = '0;
        for (int i = 0; i < stat_cnt; i++) begin
            sums[i] = '0;
            expected[i] = '0;
        end
        read_stimulus();
        cycle_limit = 40 * lines.size() + 2000;

        @(negedge rst);
        // with no events yet a full period and a flush must stay silent.
        quiet = 1;
        repeat (stat_update_period + 40) drive_cycle(0, 0, 0, 0, 0, 0);
        drive_cycle(0, 0, 0, 0, 0, 1);
        repeat (40) drive_cycle(0, 0, 0, 0, 0, 0);
        quiet = 0;

        foreach (lines[i]) begin
            kw = "";
            n = $sscanf(lines[i], "%s", kw);
            if (kw == "event") begin
                n = $sscanf(lines[i], "%s %d %d %d %d", kw, a, b, c, d);
                check_fields(n, 5, lines[i]);
                drive_cycle(1, a, b[0], c[0], d[0], 0);
            end else if (kw == "gap") begin
                n = $sscanf(lines[i], "%s %d", kw, a);
                check_fields(n, 2, lines[i]);
                repeat (a) drive_cycle(0, 0, 0, 0, 0, 0);
            end else if (kw == "flush") begin
                drive_cycle(0, 0, 0, 0, 0, 1);
            end else if (kw == "expect") begin
                n = $sscanf(lines[i], "%s %d %d %d %d %d %d %d %d", kw,
                            e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7]);
                check_fields(n, 9, lines[i]);
                for (int k = 0; k < stat_cnt; k++) begin
                    expected[k] = 32'(e[k]);
                end
                expect_seen = 1;
            end else begin
                $display("unknown stimulus line: %s", lines[i]);
                other_errors++;
            end
        end

        // drain everything with the output always ready.
        random_ready = 0;
        repeat (4) drive_cycle(0, 0, 0, 0, 0, 0);
        drive_cycle(0, 0, 0, 0, 0, 1);
        repeat (64) drive_cycle(0, 0, 0, 0, 0, 0);

        if (!expect_seen) begin
            $display("the stimulus file has no expected totals");
            other_errors++;
        end
        for (int k = 0; k < stat_cnt; k++) begin
            chan = stat_chan_e'(k);
            if (sums[k] != expected[k]) begin
                $display("MISMATCH total_%s expected %0d actual %0d",
                         chan.name(), expected[k], sums[k]);
                mismatches++;
            end
        end
        end_run();
    end

endmodule

//--- filelist.f
rtl/stats_cfg_pkg.sv
rtl/stats_if_pkg.sv
rtl/stat_event_map.sv
rtl/stat_channel_acc.sv
rtl/stat_collect_sched.sv
rtl/stats_subsys_top.sv
bench/tb_clk_gen.sv
bench/tb_stats_subsys.sv

//--- rtl/stat_channel_acc.sv
// Per-channel partial sum accumulator with collect-and-clear.
`timescale 1ns/1ps

module stat_channel_acc
    import stats_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [stat_inc_w-1:0] inc,
    input  logic                  inc_valid,
    input  logic                  clear,
    output logic [stat_acc_w-1:0] acc
);

    // a clear restarts the sum from the increment of the same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (clear) begin
            if (inc_valid) begin
                acc <= stat_acc_w'(inc);
            end else begin
                acc <= '0;
            end
        end else if (inc_valid) begin
            acc <= acc + stat_acc_w'(inc);
        end
    end

    // The sum only moves upward between collections, so a drop means it wrapped.
    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        !clear |=> acc >= $past(acc))
        else $error("channel accumulator wrapped");

endmodule

//--- rtl/stat_collect_sched.sv
// Collector FSM with total memory, period counter, flush pending shift and update output.
`timescale 1ns/1ps

module stat_collect_sched
    import stats_cfg_pkg::*;
    import stats_if_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [stat_acc_w-1:0] acc [stat_cnt],
    output logic [stat_cnt-1:0]   acc_clear,
    input  logic                  flush,
    output stat_update_t          upd,
    output logic                  upd_valid,
    input  logic                  upd_ready
);

    stat_sched_state_e state_reg, state_next;

    stat_update_t upd_reg, upd_next;
    logic         upd_valid_reg, upd_valid_next;

    logic [stat_cnt_w-1:0]    count_reg, count_next;
    logic [stat_period_w-1:0] period_reg, period_next;
    logic                     zero_reg, zero_next;
    logic                     flush_req_reg, flush_req_next;
    logic                     flush_reg, flush_next;
    logic [stat_cnt-1:0]      pend_reg, pend_next;
    logic [stat_acc_w-1:0]    ch_reg, ch_next;

    // small per-channel total store, fits in distributed RAM.
    logic [stat_data_w-1:0] mem [stat_cnt];
    logic [stat_data_w-1:0] mem_rd_data;
    logic                   mem_rd_en;
    logic                   mem_wr_en;
    logic [stat_data_w-1:0] mem_wr_data;
    logic [stat_data_w-1:0] total;

    assign upd = upd_reg;
    assign upd_valid = upd_valid_reg;

    // during the first sweep the memory holds nothing valid yet.
    assign total = zero_reg ? stat_data_w'(ch_reg) : mem_rd_data + stat_data_w'(ch_reg);

    always_comb begin
        state_next = sched_read;
        upd_next = upd_reg;
        upd_valid_next = upd_valid_reg && !upd_ready;
        count_next = count_reg;
        period_next = period_reg;
        zero_next = zero_reg;
        flush_req_next = flush_req_reg;
        flush_next = flush_reg;
        pend_next = pend_reg;
        ch_next = ch_reg;
        acc_clear = '0;
        mem_rd_en = 1'b0;
        mem_wr_en = 1'b0;
        mem_wr_data = '0;

        case (state_reg)
            sched_read: begin
                acc_clear[count_reg] = 1'b1;
                ch_next = acc[count_reg];
                mem_rd_en = 1'b1;
                state_next = sched_write;
            end
            sched_write: begin
                mem_wr_en = 1'b1;
                mem_wr_data = total;
                // channels skipped while the output was busy come around again next sweep.
                pend_next = {flush_reg || pend_reg[0], pend_reg[stat_cnt-1:1]};
                if (!upd_valid_reg && (flush_reg || pend_reg[0])) begin
                    pend_next[stat_cnt-1] = 1'b0;
                    mem_wr_data = '0;
                    upd_next.id = stat_id_w'(stat_id_base) + stat_id_w'(count_reg);
                    upd_next.count = total;
                    upd_valid_next = total != '0;
                end

                if (count_reg == stat_cnt_w'(stat_cnt - 1)) begin
                    zero_next = 1'b0;
                    flush_req_next = 1'b0;
                    flush_next = flush_req_reg;
                    count_next = '0;
                end else begin
                    count_next = count_reg + 1'b1;
                end
                state_next = sched_read;
            end
            default: begin
                state_next = sched_read;
            end
        endcase

        if (period_reg == '0 || flush) begin
            flush_req_next = 1'b1;
            period_next = stat_period_w'(stat_update_period);
        end else begin
            period_next = period_reg - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        state_reg <= state_next;
        upd_reg <= upd_next;
        upd_valid_reg <= upd_valid_next;
        count_reg <= count_next;
        period_reg <= period_next;
        zero_reg <= zero_next;
        flush_req_reg <= flush_req_next;
        flush_reg <= flush_next;
        pend_reg <= pend_next;
        ch_reg <= ch_next;

        if (rst) begin
            state_reg <= sched_read;
            upd_valid_reg <= 1'b0;
            count_reg <= '0;
            period_reg <= stat_period_w'(stat_update_period);
            zero_reg <= 1'b1;
            flush_req_reg <= 1'b0;
            flush_reg <= 1'b0;
            pend_reg <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[count_reg] <= mem_wr_data;
        end else if (mem_rd_en) begin
            mem_rd_data <= mem[count_reg];
        end
    end

    a_upd_stable: assert property (@(posedge clk) disable iff (rst)
        upd_valid && !upd_ready |=> upd_valid && $stable(upd))
        else $error("update changed while stalled");

    a_upd_nonzero: assert property (@(posedge clk) disable iff (rst)
        upd_valid |-> upd.count != '0)
        else $error("update emitted with zero count");

endmodule

//--- rtl/stat_event_map.sv
// Registered decode of one packet event into per-channel increments and strobes.
`timescale 1ns/1ps

module stat_event_map
    import stats_cfg_pkg::*;
    import stats_if_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  pkt_event_t            evt,
    output logic [stat_inc_w-1:0] inc [stat_cnt],
    output logic [stat_cnt-1:0]   inc_valid
);

    logic [stat_inc_w-1:0] inc_next [stat_cnt];
    logic [stat_cnt-1:0]   valid_next;

    always_comb begin
        // packet channels count one per event.
        for (int i = 0; i < stat_cnt; i++) begin
            inc_next[i] = stat_inc_w'(1);
        end
        inc_next[chan_good_bytes] = evt.len;
        inc_next[chan_err_bytes] = evt.len;

        valid_next = '0;
        valid_next[chan_good_pkts] = evt.valid && !evt.err;
        valid_next[chan_good_bytes] = evt.valid && !evt.err;
        valid_next[chan_err_pkts] = evt.valid && evt.err;
        valid_next[chan_err_bytes] = evt.valid && evt.err;
        valid_next[chan_bcast_pkts] = evt.valid && evt.bcast;
        valid_next[chan_mcast_pkts] = evt.valid && evt.mcast;
        valid_next[chan_runt_pkts] = evt.valid && (evt.len < stat_runt_len);
        valid_next[chan_giant_pkts] = evt.valid && (evt.len > stat_giant_len);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inc_valid <= '0;
        end else begin
            inc_valid <= valid_next;
        end
    end

    // the increment values only matter while their strobe is set.
    always_ff @(posedge clk) begin
        inc <= inc_next;
    end

endmodule

//--- rtl/stats_cfg_pkg.sv
// Statistics sizing constants, update period, id base and collector state enum.
package stats_cfg_pkg;

    // number of statistic channels and the width of a channel index.
    localparam int stat_cnt = 8;
    localparam int stat_cnt_w = 3;

    // one increment holds a full packet length.
    localparam int stat_inc_w = 16;

    // Room for a full sweep of increments before the collector drains it.
    localparam int stat_acc_w = stat_inc_w + stat_cnt_w + 1;

    // width of a running total and of an emitted count.
    localparam int stat_data_w = 32;

    localparam int stat_id_w = 8;
    localparam int stat_id_base = 16;

    // cycles between automatic flushes, the counter reloads to this value.
    localparam int stat_update_period = 256;
    localparam int stat_period_w = $clog2(stat_update_period + 1);

    typedef enum logic [0:0] {
        sched_read  = 1'b0,
        sched_write = 1'b1
    } stat_sched_state_e;

endpackage

//--- rtl/stats_if_pkg.sv
// Packet event and update structs, channel enum and frame length limits.
package stats_if_pkg;

    import stats_cfg_pkg::*;

    // channel numbers, which are also the offset of each output id.
    typedef enum logic [stat_cnt_w-1:0] {
        chan_good_pkts  = 3'd0,
        chan_good_bytes = 3'd1,
        chan_err_pkts   = 3'd2,
        chan_err_bytes  = 3'd3,
        chan_bcast_pkts = 3'd4,
        chan_mcast_pkts = 3'd5,
        chan_runt_pkts  = 3'd6,
        chan_giant_pkts = 3'd7
    } stat_chan_e;

    // frames shorter than the runt limit or longer than the giant limit are flagged.
    localparam logic [stat_inc_w-1:0] stat_runt_len = 16'd64;
    localparam logic [stat_inc_w-1:0] stat_giant_len = 16'd1518;

    typedef struct packed {
        logic                  valid;
        logic [stat_inc_w-1:0] len;
        logic                  err;
        logic                  bcast;
        logic                  mcast;
    } pkt_event_t;

    typedef struct packed {
        logic [stat_id_w-1:0]   id;
        logic [stat_data_w-1:0] count;
    } stat_update_t;

endpackage

//--- rtl/stats_subsys_top.sv
// Packet statistics top level with event map, channel accumulators and collector.
`timescale 1ns/1ps

module stats_subsys_top
    import stats_cfg_pkg::*;
    import stats_if_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  pkt_event_t   evt,
    input  logic         flush,
    output stat_update_t upd,
    output logic         upd_valid,
    input  logic         upd_ready
);

    logic [stat_inc_w-1:0] inc [stat_cnt];
    logic [stat_cnt-1:0]   inc_valid;
    logic [stat_acc_w-1:0] acc [stat_cnt];
    logic [stat_cnt-1:0]   acc_clear;

    stat_event_map u_event_map (
        .clk       (clk),
        .rst       (rst),
        .evt       (evt),
        .inc       (inc),
        .inc_valid (inc_valid)
    );

    for (genvar n = 0; n < stat_cnt; n++) begin : g_chan
        stat_channel_acc u_acc (
            .clk       (clk),
            .rst       (rst),
            .inc       (inc[n]),
            .inc_valid (inc_valid[n]),
            .clear     (acc_clear[n]),
            .acc       (acc[n])
        );
    end

    stat_collect_sched u_collect (
        .clk       (clk),
        .rst       (rst),
        .acc       (acc),
        .acc_clear (acc_clear),
        .flush     (flush),
        .upd       (upd),
        .upd_valid (upd_valid),
        .upd_ready (upd_ready)
    );

endmodule
